// ==== all.f ====
src/rv_slice_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/ex_mem.sv
src/mem_wb_stage.sv
src/pipe_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -f all.f --top-module tb_top -o tb_top \
    && ./obj_dir/tb_top | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_top.sv ====
// Pipeline slice testbench
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int N_INSTR    = 400;
    localparam int TIMEOUT_NS = N_INSTR * 4 * 3 * 10; // four cycles each, three times for stalls.

    logic                  CLK, nRST, done, fired;
    logic                  in_valid, in_ready, wb_valid, wb_ready, halt;
    rv_slice_pkg::word_t   in_instr, wb_data;
    rv_slice_pkg::regidx_t wb_rd;
    rv_slice_pkg::word_t   prog [N_INSTR + 2];
    integer                seed;
    int                    sent, ready_span, errors, wb_count;

    tb_clock u_clock (.CLK(CLK), .nRST(nRST));

    pipe_top dut (
        .CLK(CLK), .nRST(nRST),
        .in_valid_i(in_valid), .in_ready_o(in_ready), .in_instr_i(in_instr),
        .wb_valid_o(wb_valid), .wb_ready_i(wb_ready), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .halt_o(halt)
    );

    tb_checker u_checker (
        .CLK(CLK), .nRST(nRST),
        .in_valid_i(in_valid), .in_ready_i(in_ready), .in_instr_i(in_instr),
        .wb_valid_i(wb_valid), .wb_ready_i(wb_ready), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .halt_i(halt), .done_i(done), .errors_o(errors), .wb_count_o(wb_count)
    );

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // ****************************************
    // random instruction over x0 to x7
    // ****************************************
    function automatic rv_slice_pkg::word_t make_instr();
        rv_slice_pkg::regidx_t rd, rs1, rs2, base;
        logic [6:0]            f7;
        logic [2:0]            f3;
        logic [11:0]           imm, offs;
        int                    kind;
        rd   = 5'(rand_below(8));
        rs1  = 5'(rand_below(8));
        rs2  = 5'(rand_below(8));
        imm  = 12'(rand_below(4096));
        offs = 12'(rand_below(16) * 4); // word offsets 0 to 15.
        base = (rand_below(4) == 0) ? rs1 : 5'd0;
        kind = rand_below(10);
        case (rand_below(5))
            0:       f3 = rv_slice_pkg::F3_XOR;
            1:       f3 = rv_slice_pkg::F3_OR;
            2:       f3 = rv_slice_pkg::F3_AND;
            3:       f3 = rv_slice_pkg::F3_SLT;
            default: f3 = rv_slice_pkg::F3_ADD;
        endcase
        f7 = (f3 == rv_slice_pkg::F3_ADD && rand_below(2) == 1) ? rv_slice_pkg::F7_SUB : 7'd0;
        if (kind < 4) begin
            return {f7, rs2, rs1, f3, rd, rv_slice_pkg::OPC_OP};
        end else if (kind < 6) begin
            if (f3 == rv_slice_pkg::F3_SLT) begin
                f3 = rv_slice_pkg::F3_ADD;
            end
            return {imm, rs1, f3, rd, rv_slice_pkg::OPC_OP_IMM};
        end else if (kind < 8) begin
            return {offs, base, rv_slice_pkg::F3_LW, rd, rv_slice_pkg::OPC_LOAD};
        end
        return {offs[11:5], rs2, base, 3'b010, offs[4:0], rv_slice_pkg::OPC_STORE}; // SW.
    endfunction

    initial begin
        seed       = 32'h6182_81e8;
        in_valid   = 1'b0;
        in_instr   = '0;
        wb_ready   = 1'b0;
        done       = 1'b0;
        fired      = 1'b0;
        sent       = 0;
        ready_span = 0;
        for (int i = 0; i < N_INSTR; i++) begin
            prog[i] = make_instr();
        end
        prog[N_INSTR]     = {25'b0, rv_slice_pkg::OPC_SYSTEM}; // HALT.
        prog[N_INSTR + 1] = {12'd1, 5'd1, rv_slice_pkg::F3_ADD, 5'd1, rv_slice_pkg::OPC_OP_IMM};
        @(posedge nRST);
        while (!halt) begin
            @(negedge CLK);
            fired = in_valid && in_ready; // the transfer happens at the next rising edge.
            @(posedge CLK);
            #1;
            if (fired) begin
                sent++;
                in_valid = 1'b0;
            end
            if (!in_valid && sent <= N_INSTR && rand_below(4) != 0) begin
                in_valid = 1'b1;
                in_instr = prog[sent];
            end
            if (ready_span == 0) begin
                wb_ready   = rand_below(3) != 0;
                ready_span = 1 + rand_below(6);
            end
            ready_span--;
        end
        // an instruction offered after HALT must never be taken.
        in_valid = 1'b1;
        in_instr = prog[N_INSTR + 1];
        wb_ready = 1'b1;
        repeat (5) @(posedge CLK);
        #1;
        in_valid = 1'b0;
        done     = 1'b1;
        @(negedge CLK);
        #1;
        $display("errors: %0d, writebacks: %0d, instructions: %0d", errors, wb_count, sent);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: HALT did not retire within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_checker.sv ====
// Writeback and halt checker
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire                        in_valid_i,
    input  wire                        in_ready_i,
    input  wire rv_slice_pkg::word_t   in_instr_i,
    input  wire                        wb_valid_i,
    input  wire                        wb_ready_i,
    input  wire rv_slice_pkg::regidx_t wb_rd_i,
    input  wire rv_slice_pkg::word_t   wb_data_i,
    input  wire                        halt_i,
    input  wire                        done_i,
    output int                         errors_o,
    output int                         wb_count_o
);

    typedef struct packed {
        rv_slice_pkg::regidx_t rd;
        rv_slice_pkg::word_t   data;
    } wb_t;

    rv_slice_pkg::word_t   model_regs [32];
    rv_slice_pkg::word_t   model_mem [rv_slice_pkg::DMEM_WORDS];
    wb_t                   exp_q [$];
    int                    errors = 0;
    int                    wb_count = 0;
    int                    model_count = 0;
    logic                  halt_accepted = 1'b0;
    logic                  halt_seen = 1'b0;
    logic                  finished = 1'b0;
    logic                  was_reset = 1'b0;
    rv_slice_pkg::regidx_t load_rd = '0; // rd of a load sitting in decode/execute.

    assign errors_o   = errors;
    assign wb_count_o = wb_count;

    function automatic rv_slice_pkg::word_t alu_model(input logic [2:0]          f3,
                                                      input logic                sub,
                                                      input rv_slice_pkg::word_t a,
                                                      input rv_slice_pkg::word_t b);
        case (f3)
            rv_slice_pkg::F3_XOR: return a ^ b;
            rv_slice_pkg::F3_OR:  return a | b;
            rv_slice_pkg::F3_AND: return a & b;
            rv_slice_pkg::F3_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:              return sub ? a - b : a + b;
        endcase
    endfunction

    // true when the word takes register r as a source operand.
    function automatic logic reads_reg(input rv_slice_pkg::word_t   word,
                                       input rv_slice_pkg::regidx_t r);
        rv_slice_pkg::instr_u ins;
        ins = word;
        case (ins.r.opcode)
            rv_slice_pkg::OPC_OP, rv_slice_pkg::OPC_STORE: begin
                return ins.r.rs1 == r || ins.r.rs2 == r;
            end
            rv_slice_pkg::OPC_OP_IMM, rv_slice_pkg::OPC_LOAD: begin
                return ins.i.rs1 == r;
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    // ISA-level effect of one instruction on the model registers and memory.
    function automatic void exec_model(input rv_slice_pkg::word_t word, output logic wr,
                                       output wb_t res);
        rv_slice_pkg::instr_u ins;
        rv_slice_pkg::word_t  a, addr, simm;
        ins      = word;
        a        = model_regs[ins.r.rs1];
        simm     = {{20{ins.i.imm[11]}}, ins.i.imm};
        wr       = 1'b0;
        res.rd   = ins.r.rd;
        res.data = '0;
        case (ins.r.opcode)
            rv_slice_pkg::OPC_OP: begin
                res.data = alu_model(ins.r.funct3, ins.r.funct7 == rv_slice_pkg::F7_SUB, a,
                                     model_regs[ins.r.rs2]);
                wr       = 1'b1;
            end
            rv_slice_pkg::OPC_OP_IMM: begin
                res.data = alu_model(ins.i.funct3, 1'b0, a, simm);
                wr       = 1'b1;
            end
            rv_slice_pkg::OPC_LOAD: begin
                addr     = a + simm;
                res.data = model_mem[addr[7:2]];
                wr       = 1'b1;
            end
            rv_slice_pkg::OPC_STORE: begin
                addr = a + {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
                model_mem[addr[7:2]] = model_regs[ins.s.rs2];
            end
            default: begin
            end
        endcase
        wr = wr && ins.r.rd != 5'd0; // x0 never writes back.
        if (wr) begin
            model_regs[ins.r.rd] = res.data;
        end
    endfunction

    // ****************************************
    // compare at the falling edge
    // ****************************************
    always @(negedge CLK) begin
        wb_t  res;
        logic wr;
        logic exp_ready;
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            for (int i = 0; i < rv_slice_pkg::DMEM_WORDS; i++) begin
                model_mem[i] = '0;
            end
            exp_q.delete();
            halt_accepted = 1'b0;
            halt_seen     = 1'b0;
            was_reset     = 1'b1;
            load_rd       = '0;
            if (wb_valid_i || halt_i || in_ready_i) begin
                errors++;
                $display("outputs not low during reset at %0t", $time);
            end
        end else begin
            // ready needs an advancing pipe, no load-use hazard and no HALT taken.
            exp_ready = !was_reset && !halt_accepted && (!wb_valid_i || wb_ready_i) &&
                        !(in_valid_i && load_rd != 5'd0 && reads_reg(in_instr_i, load_rd));
            if (in_ready_i != exp_ready) begin
                errors++;
                $display("FAIL %0t: in_ready_o = %0b, expected %0b", $time, in_ready_i,
                         exp_ready);
            end
            was_reset = 1'b0;
            if (in_valid_i && in_ready_i) begin
                load_rd = (in_instr_i[6:0] == rv_slice_pkg::OPC_LOAD) ? in_instr_i[11:7] : 5'd0;
                if (in_instr_i[6:0] == rv_slice_pkg::OPC_SYSTEM) begin
                    halt_accepted = 1'b1;
                end else begin
                    exec_model(in_instr_i, wr, res);
                    if (wr) begin
                        exp_q.push_back(res);
                        model_count++;
                    end
                end
            end else if (!wb_valid_i || wb_ready_i) begin
                load_rd = 5'd0; // the load moves on and a bubble takes its place.
            end
            if (wb_valid_i && wb_ready_i) begin
                wb_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected writeback to x%0d at %0t", wb_rd_i, $time);
                end else begin
                    res = exp_q.pop_front();
                    if (wb_rd_i != res.rd) begin
                        errors++;
                        $display("FAIL %0t: wb_rd_o = %0d, expected %0d", $time, wb_rd_i, res.rd);
                    end
                    if (wb_data_i != res.data) begin
                        errors++;
                        $display("FAIL %0t: wb_data_o = %h, expected %h", $time, wb_data_i,
                                 res.data);
                    end
                end
            end
            if (halt_i && !halt_seen) begin
                halt_seen = 1'b1;
                if (!halt_accepted || exp_q.size() != 0) begin
                    errors++;
                    $display("halt_o rose early, %0d writebacks still owed", exp_q.size());
                end
            end else if (halt_seen && !halt_i) begin
                errors++;
                $display("halt_o dropped at %0t", $time);
            end
            if (done_i && !finished) begin
                finished = 1'b1;
                if (!halt_seen || wb_count != model_count) begin
                    errors++;
                    $display("%0d writebacks seen but %0d predicted, halt seen %0b",
                             wb_count, model_count, halt_seen);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic nRST
);

    localparam int HALF_PERIOD_NS = 5;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD_NS CLK = ~CLK;
    end

    // reset spans two rising edges.
    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

`default_nettype wire

// ==== src/pipe_top.sv ====
// Integer pipeline slice top level
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire                        in_valid_i,
    output logic                       in_ready_o,
    input  wire rv_slice_pkg::word_t   in_instr_i,
    output logic                       wb_valid_o,
    input  wire                        wb_ready_i,
    output rv_slice_pkg::regidx_t      wb_rd_o,
    output rv_slice_pkg::word_t        wb_data_o,
    output logic                       halt_o
);

    logic                  adv, accept, hazard, started_q, halted_q, wb_we, fwd1_valid;
    logic                  id_valid, id_use_imm, id_reg_wr, id_mem_rd, id_mem_wr, id_halt;
    rv_slice_pkg::alu_op_e id_op;
    rv_slice_pkg::regidx_t id_rs1, id_rs2, id_rd, xm_rd;
    rv_slice_pkg::word_t   id_a, id_b, id_imm, alu_result, store_data;
    logic                  xm_valid, xm_reg_wr, xm_mem_rd, xm_mem_wr, xm_halt;
    rv_slice_pkg::word_t   xm_alu_result, xm_store_data;

    // ****************************************
    // advance and stall
    // ****************************************
    assign adv        = !wb_valid_o || wb_ready_i; // one enable for every stage.
    assign in_ready_o = started_q && adv && !hazard && !halted_q;
    assign accept     = in_valid_i && in_ready_o;
    assign fwd1_valid = xm_valid && xm_reg_wr && !xm_mem_rd; // load data is not ready yet.

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            started_q <= 1'b0;
            halted_q  <= 1'b0;
        end else begin
            started_q <= 1'b1;
            if (accept && in_instr_i[6:0] == rv_slice_pkg::OPC_SYSTEM) begin
                halted_q <= 1'b1; // nothing is taken after HALT.
            end
        end
    end

    decode_stage u_decode (
        .CLK(CLK), .nRST(nRST),
        .in_valid_i(in_valid_i), .in_instr_i(in_instr_i),
        .accept_i(accept), .adv_i(adv),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
        .hazard_o(hazard), .id_valid_o(id_valid), .id_op_o(id_op),
        .id_rs1_o(id_rs1), .id_rs2_o(id_rs2), .id_rd_o(id_rd),
        .id_a_o(id_a), .id_b_o(id_b), .id_imm_o(id_imm), .id_use_imm_o(id_use_imm),
        .id_reg_wr_o(id_reg_wr), .id_mem_rd_o(id_mem_rd), .id_mem_wr_o(id_mem_wr),
        .id_halt_o(id_halt)
    );

    execute_stage u_execute (
        .id_op_i(id_op), .id_a_i(id_a), .id_b_i(id_b), .id_imm_i(id_imm),
        .id_use_imm_i(id_use_imm), .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
        .fwd1_valid_i(fwd1_valid), .fwd1_rd_i(xm_rd), .fwd1_data_i(xm_alu_result),
        .fwd2_valid_i(wb_valid_o), .fwd2_rd_i(wb_rd_o), .fwd2_data_i(wb_data_o),
        .alu_result_o(alu_result), .store_data_o(store_data)
    );

    ex_mem u_ex_mem (
        .CLK(CLK), .nRST(nRST), .adv_i(adv), .valid_i(id_valid),
        .alu_result_i(alu_result), .store_data_i(store_data), .rd_i(id_rd),
        .reg_wr_i(id_reg_wr), .mem_rd_i(id_mem_rd), .mem_wr_i(id_mem_wr), .halt_i(id_halt),
        .valid_o(xm_valid), .alu_result_o(xm_alu_result), .store_data_o(xm_store_data),
        .rd_o(xm_rd), .reg_wr_o(xm_reg_wr), .mem_rd_o(xm_mem_rd), .mem_wr_o(xm_mem_wr),
        .halt_o(xm_halt)
    );

    mem_wb_stage u_mem_wb (
        .CLK(CLK), .nRST(nRST),
        .xm_valid_i(xm_valid), .xm_alu_result_i(xm_alu_result),
        .xm_store_data_i(xm_store_data), .xm_rd_i(xm_rd), .xm_reg_wr_i(xm_reg_wr),
        .xm_mem_rd_i(xm_mem_rd), .xm_mem_wr_i(xm_mem_wr), .xm_halt_i(xm_halt),
        .adv_i(adv), .wb_valid_o(wb_valid_o), .wb_ready_i(wb_ready_i),
        .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .wb_we_o(wb_we), .halt_o(halt_o)
    );

endmodule

`default_nettype wire

// ==== src/mem_wb_stage.sv ====
// Memory and writeback stage
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire                        xm_valid_i,
    input  wire rv_slice_pkg::word_t   xm_alu_result_i,
    input  wire rv_slice_pkg::word_t   xm_store_data_i,
    input  wire rv_slice_pkg::regidx_t xm_rd_i,
    input  wire                        xm_reg_wr_i,
    input  wire                        xm_mem_rd_i,
    input  wire                        xm_mem_wr_i,
    input  wire                        xm_halt_i,
    input  wire                        adv_i,
    output logic                       wb_valid_o,
    input  wire                        wb_ready_i,
    output rv_slice_pkg::regidx_t      wb_rd_o,
    output rv_slice_pkg::word_t        wb_data_o,
    output logic                       wb_we_o,
    output logic                       halt_o
);

    rv_slice_pkg::word_t                         dmem [rv_slice_pkg::DMEM_WORDS];
    logic [$clog2(rv_slice_pkg::DMEM_WORDS)-1:0] idx;
    rv_slice_pkg::word_t                         result;

    assign idx    = xm_alu_result_i[$clog2(rv_slice_pkg::DMEM_WORDS)+1:2];
    assign result = xm_mem_rd_i ? dmem[idx] : xm_alu_result_i;

    // a store lands in the cycle it leaves the execute/memory latch.
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < rv_slice_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (adv_i && xm_valid_i && xm_mem_wr_i) begin
            dmem[idx] <= xm_store_data_i;
        end
    end

    // ****************************************
    // MEM/WB register
    // ****************************************
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_valid_o <= 1'b0;
            halt_o     <= 1'b0;
        end else if (adv_i) begin
            wb_valid_o <= xm_valid_i && xm_reg_wr_i && xm_rd_i != '0; // x0 needs no writeback.
            if (xm_valid_i && xm_halt_i) begin
                halt_o <= 1'b1; // sticky until reset.
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (adv_i) begin
            wb_rd_o   <= xm_rd_i;
            wb_data_o <= result;
        end
    end

    assign wb_we_o = wb_valid_o && wb_ready_i; // register file writes on handshake.

endmodule

`default_nettype wire

// ==== src/ex_mem.sv ====
// Execute/memory pipeline latch
`timescale 1ns/1ps
`default_nettype none

module ex_mem (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire                        adv_i,
    input  wire                        valid_i,
    input  wire rv_slice_pkg::word_t   alu_result_i,
    input  wire rv_slice_pkg::word_t   store_data_i,
    input  wire rv_slice_pkg::regidx_t rd_i,
    input  wire                        reg_wr_i,
    input  wire                        mem_rd_i,
    input  wire                        mem_wr_i,
    input  wire                        halt_i,
    output logic                       valid_o,
    output rv_slice_pkg::word_t        alu_result_o,
    output rv_slice_pkg::word_t        store_data_o,
    output rv_slice_pkg::regidx_t      rd_o,
    output logic                       reg_wr_o,
    output logic                       mem_rd_o,
    output logic                       mem_wr_o,
    output logic                       halt_o
);

    // ****************************************
    // latch held while the pipe is stalled
    // ****************************************
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_o      <= 1'b0;
            alu_result_o <= '0;
            store_data_o <= '0;
            rd_o         <= '0;
            reg_wr_o     <= 1'b0;
            mem_rd_o     <= 1'b0;
            mem_wr_o     <= 1'b0;
            halt_o       <= 1'b0;
        end else if (adv_i) begin
            // an empty execute stage turns into an all-zero bubble.
            valid_o      <= valid_i;
            alu_result_o <= valid_i ? alu_result_i : '0;
            store_data_o <= valid_i ? store_data_i : '0;
            rd_o         <= valid_i ? rd_i : '0;
            reg_wr_o     <= valid_i && reg_wr_i;
            mem_rd_o     <= valid_i && mem_rd_i;
            mem_wr_o     <= valid_i && mem_wr_i;
            halt_o       <= valid_i && halt_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
// Execute stage with operand forwarding
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire rv_slice_pkg::alu_op_e id_op_i,
    input  wire rv_slice_pkg::word_t   id_a_i,
    input  wire rv_slice_pkg::word_t   id_b_i,
    input  wire rv_slice_pkg::word_t   id_imm_i,
    input  wire                        id_use_imm_i,
    input  wire rv_slice_pkg::regidx_t id_rs1_i,
    input  wire rv_slice_pkg::regidx_t id_rs2_i,
    input  wire                        fwd1_valid_i,
    input  wire rv_slice_pkg::regidx_t fwd1_rd_i,
    input  wire rv_slice_pkg::word_t   fwd1_data_i,
    input  wire                        fwd2_valid_i,
    input  wire rv_slice_pkg::regidx_t fwd2_rd_i,
    input  wire rv_slice_pkg::word_t   fwd2_data_i,
    output rv_slice_pkg::word_t        alu_result_o,
    output rv_slice_pkg::word_t        store_data_o
);

    rv_slice_pkg::word_t a, b_reg, b;

    // the execute/memory latch holds the newer value, so it is checked first.
    function automatic rv_slice_pkg::word_t pick(rv_slice_pkg::regidx_t rs,
                                                 rv_slice_pkg::word_t   rf_val);
        if (rs == '0) begin
            return rf_val;
        end
        if (fwd1_valid_i && fwd1_rd_i == rs) begin
            return fwd1_data_i;
        end
        if (fwd2_valid_i && fwd2_rd_i == rs) begin
            return fwd2_data_i;
        end
        return rf_val;
    endfunction

    always_comb begin
        a     = pick(id_rs1_i, id_a_i);
        b_reg = pick(id_rs2_i, id_b_i);
        b     = id_use_imm_i ? id_imm_i : b_reg;
        case (id_op_i)
            rv_slice_pkg::ALU_SUB: alu_result_o = a - b;
            rv_slice_pkg::ALU_AND: alu_result_o = a & b;
            rv_slice_pkg::ALU_OR:  alu_result_o = a | b;
            rv_slice_pkg::ALU_XOR: alu_result_o = a ^ b;
            rv_slice_pkg::ALU_SLT: alu_result_o = {31'b0, $signed(a) < $signed(b)};
            default:               alu_result_o = a + b;
        endcase
        store_data_o = b_reg; // rs2 still carries the store data.
    end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
// Decode stage and decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire                        in_valid_i,
    input  wire rv_slice_pkg::word_t   in_instr_i,
    input  wire                        accept_i,
    input  wire                        adv_i,
    input  wire                        wb_we_i,
    input  wire rv_slice_pkg::regidx_t wb_rd_i,
    input  wire rv_slice_pkg::word_t   wb_data_i,
    output logic                       hazard_o,
    output logic                       id_valid_o,
    output rv_slice_pkg::alu_op_e      id_op_o,
    output rv_slice_pkg::regidx_t      id_rs1_o,
    output rv_slice_pkg::regidx_t      id_rs2_o,
    output rv_slice_pkg::regidx_t      id_rd_o,
    output rv_slice_pkg::word_t        id_a_o,
    output rv_slice_pkg::word_t        id_b_o,
    output rv_slice_pkg::word_t        id_imm_o,
    output logic                       id_use_imm_o,
    output logic                       id_reg_wr_o,
    output logic                       id_mem_rd_o,
    output logic                       id_mem_wr_o,
    output logic                       id_halt_o
);

    rv_slice_pkg::instr_u  ins;
    rv_slice_pkg::alu_op_e dec_op;
    rv_slice_pkg::regidx_t dec_rs1, dec_rs2;
    rv_slice_pkg::word_t   dec_imm, rf_a, rf_b;
    logic                  is_op, is_imm, is_ld, is_st, is_sys;

    assign ins    = in_instr_i;
    assign is_op  = ins.r.opcode == rv_slice_pkg::OPC_OP;
    assign is_imm = ins.i.opcode == rv_slice_pkg::OPC_OP_IMM;
    assign is_ld  = ins.i.opcode == rv_slice_pkg::OPC_LOAD && ins.i.funct3 == rv_slice_pkg::F3_LW;
    assign is_st  = ins.s.opcode == rv_slice_pkg::OPC_STORE;
    assign is_sys = ins.r.opcode == rv_slice_pkg::OPC_SYSTEM;

    // unused source fields read as x0 so they never forward or stall.
    assign dec_rs1 = is_sys ? '0 : ins.r.rs1;
    assign dec_rs2 = (is_op || is_st) ? ins.r.rs2 : '0;
    assign dec_imm = is_st ? {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo}
                           : {{20{ins.i.imm[11]}}, ins.i.imm};

    always_comb begin
        dec_op = rv_slice_pkg::ALU_ADD; // loads and stores add the offset.
        if (is_op || is_imm) begin
            case (ins.r.funct3)
                rv_slice_pkg::F3_ADD: dec_op = (is_op && ins.r.funct7 == rv_slice_pkg::F7_SUB)
                                               ? rv_slice_pkg::ALU_SUB : rv_slice_pkg::ALU_ADD;
                rv_slice_pkg::F3_XOR: dec_op = rv_slice_pkg::ALU_XOR;
                rv_slice_pkg::F3_OR:  dec_op = rv_slice_pkg::ALU_OR;
                rv_slice_pkg::F3_AND: dec_op = rv_slice_pkg::ALU_AND;
                rv_slice_pkg::F3_SLT: dec_op = rv_slice_pkg::ALU_SLT;
                default:              dec_op = rv_slice_pkg::ALU_ADD;
            endcase
        end
    end

    // a load in execute cannot forward its data in time.
    assign hazard_o = in_valid_i && id_valid_o && id_mem_rd_o && id_rd_o != '0 &&
                      (id_rd_o == dec_rs1 || id_rd_o == dec_rs2);

    reg_file u_rf (
        .CLK(CLK), .nRST(nRST),
        .rs1_i(dec_rs1), .rs2_i(dec_rs2),
        .rs1_data_o(rf_a), .rs2_data_o(rf_b),
        .we_i(wb_we_i), .wr_rd_i(wb_rd_i), .wr_data_i(wb_data_i)
    );

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            id_valid_o  <= 1'b0;
            id_reg_wr_o <= 1'b0;
            id_mem_rd_o <= 1'b0;
            id_mem_wr_o <= 1'b0;
            id_halt_o   <= 1'b0;
        end else if (accept_i) begin
            id_valid_o  <= 1'b1;
            id_reg_wr_o <= is_op || is_imm || is_ld;
            id_mem_rd_o <= is_ld;
            id_mem_wr_o <= is_st;
            id_halt_o   <= is_sys;
        end else if (adv_i) begin // nothing taken, so a bubble moves in.
            id_valid_o  <= 1'b0;
            id_reg_wr_o <= 1'b0;
            id_mem_rd_o <= 1'b0;
            id_mem_wr_o <= 1'b0;
            id_halt_o   <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept_i) begin
            id_op_o      <= dec_op;
            id_rs1_o     <= dec_rs1;
            id_rs2_o     <= dec_rs2;
            id_rd_o      <= ins.r.rd;
            id_a_o       <= rf_a;
            id_b_o       <= rf_b;
            id_imm_o     <= dec_imm;
            id_use_imm_o <= !is_op;
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire rv_slice_pkg::regidx_t rs1_i,
    input  wire rv_slice_pkg::regidx_t rs2_i,
    output rv_slice_pkg::word_t        rs1_data_o,
    output rv_slice_pkg::word_t        rs2_data_o,
    input  wire                        we_i,
    input  wire rv_slice_pkg::regidx_t wr_rd_i,
    input  wire rv_slice_pkg::word_t   wr_data_i
);

    rv_slice_pkg::word_t regs [32];

    // a register being written this cycle reads as its new value.
    function automatic rv_slice_pkg::word_t read_port(rv_slice_pkg::regidx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (we_i && wr_rd_i == idx) begin
            return wr_data_i;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wr_rd_i != '0) begin
            regs[wr_rd_i] <= wr_data_i; // x0 is never written.
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_slice_pkg.sv ====
// RV32I slice shared definitions
`default_nettype none

package rv_slice_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regidx_t;

    // ****************************************
    // opcodes and function codes
    // ****************************************
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam int DMEM_WORDS = 64; // addressed by bits 7:2.

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // ****************************************
    // instruction formats
    // ****************************************
    typedef struct packed {
        logic [6:0] funct7;
        regidx_t    rs2;
        regidx_t    rs1;
        logic [2:0] funct3;
        regidx_t    rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        regidx_t     rs1;
        logic [2:0]  funct3;
        regidx_t     rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        regidx_t    rs2;
        regidx_t    rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } instr_u;

endpackage

`default_nettype wire
